/* compile.f */
hw/debug_pkg.sv
hw/cmd_decoder.sv
hw/stream_fifo.sv
hw/cmd_executor.sv
hw/core_control.sv
hw/debug_interpreter.sv
verification/tb_mem_model.sv
verification/tb_debug_interpreter.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_debug_interpreter \
    -f compile.f -o tb_sim || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "TESTBENCH PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* verification/tb_debug_interpreter.sv */
module tb_debug_interpreter import debug_pkg::*; ();

    localparam word_t ID               = 32'h1D0C_B00E;
    localparam int    RESET_CLK_CYCLES = 20;
    localparam int    CMD_DEPTH        = 4;
    localparam int    REPLY_DEPTH      = 4;
    localparam int    BURST_LEN        = CMD_DEPTH + REPLY_DEPTH + 4;

    typedef enum {READY_HIGH, READY_RANDOM, READY_LOW} ready_mode_e;

    logic        clk = 1'b0;
    logic        reset;
    logic        cmd_valid;
    logic        cmd_ready;
    word_t       cmd_data;
    logic        reply_valid;
    logic        reply_ready;
    word_t       reply_data;
    mem_req_t    mem_req;
    logic        mem_response;
    word_t       mem_read_data;
    logic        core_clk_enable;
    logic        core_reset;
    logic        write_pulse;
    word_t       cycles_to_pulse;

    word_t       acc_model;
    word_t       mem_model [word_t];
    word_t       exp_q [$];
    word_t       exp_head;
    int          exp_count;
    int          reply_idx;
    word_t       exp_pulse;
    int          cmds_sent;
    int          pulses_sent;
    int          pulses_seen;
    int          resets_sent;
    int          resets_done;
    int          reset_run;
    int          check_errors;
    int          other_errors;
    int          low_cycles;
    logic        burst_done;
    logic        stall_seen;
    ready_mode_e ready_mode;

    always #5 clk = ~clk;

    debug_interpreter #(
        .ID               (ID),
        .RESET_CLK_CYCLES (RESET_CLK_CYCLES),
        .CMD_DEPTH        (CMD_DEPTH),
        .REPLY_DEPTH      (REPLY_DEPTH)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .cmd_valid       (cmd_valid),
        .cmd_ready       (cmd_ready),
        .cmd_data        (cmd_data),
        .reply_valid     (reply_valid),
        .reply_ready     (reply_ready),
        .reply_data      (reply_data),
        .mem_req         (mem_req),
        .mem_response    (mem_response),
        .mem_read_data   (mem_read_data),
        .core_clk_enable (core_clk_enable),
        .core_reset      (core_reset),
        .write_pulse     (write_pulse),
        .cycles_to_pulse (cycles_to_pulse)
    );

    tb_mem_model u_mem (
        .clk           (clk),
        .reset         (reset),
        .mem_req       (mem_req),
        .mem_response  (mem_response),
        .mem_read_data (mem_read_data)
    );

    function automatic void report_mismatch(string name, word_t got, word_t expected);
        check_errors++;
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
    endfunction

    function automatic void count_failure(string msg);
        other_errors++;
        $display("Error: %s", msg);
    endfunction

    task automatic finish_run();
        $display("Errors: %0d value, %0d other; %0d replies, %0d words sent",
                 check_errors, other_errors, reply_idx, cmds_sent);
        if (check_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_word(input word_t w);
        cmd_valid = 1'b1;
        cmd_data  = w;
        cmds_sent++;
        @(posedge clk);
        while (!cmd_ready) @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    // Reference model applied in send order, replies queued the same way
    task automatic send_cmd(input opcode_e op, input arg_t arg);
        word_t arg_w;
        arg_w = word_t'(arg);
        case (op)
            OP_ACC_UPPER: acc_model = (arg_w << 8) | (acc_model & 32'h0000_00ff);
            OP_ACC_LOWER: acc_model = (acc_model & 32'hffff_ff00) | (arg_w & 32'h0000_00ff);
            OP_ACC_ADD:   acc_model = acc_model + word_t'(int'($signed(arg)));
            OP_WRITE_ACC: mem_model[arg_w] = acc_model;
            OP_WRITE_N:   mem_model[acc_model] = arg_w;
            OP_MEM_READ:  exp_q.push_back(mem_model[arg_w]);
            OP_READ_ACC:  exp_q.push_back(mem_model[acc_model]);
            OP_PING:      exp_q.push_back(ID);
            OP_GET_ACC:   exp_q.push_back(acc_model);
            OP_CLK_PULSE: begin
                exp_pulse = arg_w;
                pulses_sent++;
            end
            OP_CORE_RESET: resets_sent++;
            default: ;
        endcase
        send_word({arg, op});
    endtask

    task automatic send_write(input arg_t addr, input word_t data);
        mem_model[word_t'(addr)] = data;
        send_word({addr, OP_MEM_WRITE});
        send_word(data);
    endtask

    task automatic drain_replies();
        while (reply_idx < exp_q.size()) wait_cycle();
    endtask

    always @(posedge clk) begin
        int idx_next;
        if (reset) begin
            reply_idx   <= 0;
            exp_head    <= '0;
            exp_count   <= 0;
            pulses_seen <= 0;
            reset_run   <= 0;
            resets_done <= 0;
        end else begin
            idx_next = reply_idx + ((reply_valid && reply_ready) ? 1 : 0);
            reply_idx <= idx_next;
            exp_count <= exp_q.size() - idx_next;
            exp_head  <= (idx_next < exp_q.size()) ? exp_q[idx_next] : '0;
            if (write_pulse) begin
                pulses_seen <= pulses_seen + 1;
            end
            reset_run <= core_reset ? reset_run + 1 : 0;  // Length of the current core reset
            if (!core_reset && reset_run != 0) begin
                resets_done <= resets_done + 1;
            end
        end
    end

    initial begin
        reply_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            case (ready_mode)
                READY_RANDOM: reply_ready = ($urandom_range(0, 3) != 0);
                READY_LOW:    reply_ready = 1'b0;
                default:      reply_ready = 1'b1;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (reply_valid && reply_ready) |-> (exp_count > 0))
        else count_failure("reply arrived with no command waiting for one");

    assert property (@(posedge clk) disable iff (reset)
        (reply_valid && reply_ready && exp_count > 0) |-> (reply_data == exp_head))
        else report_mismatch("reply_data", $sampled(reply_data), $sampled(exp_head));

    assert property (@(posedge clk) disable iff (reset)
        write_pulse |-> (cycles_to_pulse == exp_pulse))
        else report_mismatch("cycles_to_pulse", $sampled(cycles_to_pulse), $sampled(exp_pulse));

    assert property (@(posedge clk) disable iff (reset)
        (write_pulse || core_reset) |-> core_clk_enable)
        else count_failure("core_clk_enable low during a pulse or core reset");

    assert property (@(posedge clk) disable iff (reset)
        $fell(core_reset) |-> (reset_run == RESET_CLK_CYCLES))
        else report_mismatch("core_reset cycles", $sampled(reset_run), RESET_CLK_CYCLES);

    assert property (@(posedge clk) disable iff (reset)
        $fell(core_reset) |-> !core_clk_enable)
        else count_failure("core_clk_enable still high after the core reset sequence");

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < 200 * (cmds_sent + 1)) begin
            @(posedge clk);
            cycles++;
        end
        count_failure($sformatf("timeout after %0d cycles, %0d words sent", cycles, cmds_sent));
        finish_run();
    end

    initial begin
        arg_t  addr;
        word_t data;
        void'($urandom(32'hc5bd056e));
        reset      = 1'b1;
        cmd_valid  = 1'b0;
        cmd_data   = '0;
        acc_model  = '0;
        exp_pulse  = '0;
        ready_mode = READY_HIGH;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        send_cmd(OP_PING, '0);
        send_word(32'h00AB_CD58);  // X is no opcode
        send_cmd(OP_PING, 24'h000001);
        drain_replies();

        ready_mode = READY_RANDOM;
        send_cmd(OP_ACC_UPPER, 24'h123456);
        send_cmd(OP_ACC_LOWER, 24'h000078);
        send_cmd(OP_GET_ACC, '0);
        send_cmd(OP_ACC_ADD, 24'hFFFFF0);  // Minus 16
        send_cmd(OP_GET_ACC, '0);
        for (int i = 0; i < 8; i++) begin
            case ($urandom_range(0, 2))
                0:       send_cmd(OP_ACC_UPPER, arg_t'($urandom()));
                1:       send_cmd(OP_ACC_LOWER, arg_t'($urandom()));
                default: send_cmd(OP_ACC_ADD, arg_t'($urandom()));
            endcase
            send_cmd(OP_GET_ACC, '0);
        end
        drain_replies();

        send_write(24'h000040, 32'hCAFE_F00D);
        send_cmd(OP_MEM_READ, 24'h000040);
        send_cmd(OP_ACC_UPPER, '0);
        send_cmd(OP_ACC_LOWER, 24'h000080);
        send_cmd(OP_WRITE_ACC, 24'h000044);
        send_cmd(OP_WRITE_N, 24'h001234);
        send_cmd(OP_READ_ACC, '0);
        send_cmd(OP_MEM_READ, 24'h000044);
        for (int i = 0; i < 6; i++) begin
            addr = arg_t'($urandom_range(0, 63) * 8 + 32'h200);
            data = $urandom();
            send_write(addr, data);
            send_cmd(OP_MEM_READ, addr);
            send_cmd(OP_WRITE_ACC, addr + 24'd4);
            send_cmd(OP_MEM_READ, addr + 24'd4);
        end
        drain_replies();

        send_cmd(OP_CLK_PULSE, 24'd37);
        send_cmd(OP_PING, '0);
        drain_replies();
        assert (core_clk_enable) else count_failure("core_clk_enable low after C");
        send_cmd(OP_CLK_STOP, '0);
        send_cmd(OP_PING, '0);
        drain_replies();
        assert (!core_clk_enable) else count_failure("core_clk_enable high after S");
        send_cmd(OP_CLK_RESUME, '0);
        send_cmd(OP_PING, '0);
        drain_replies();
        assert (core_clk_enable) else count_failure("core_clk_enable low after r");

        send_cmd(OP_CORE_RESET, '0);
        while (resets_done != resets_sent) wait_cycle();

        for (int i = 0; i < BURST_LEN; i++) begin
            send_write(arg_t'(32'h100 + 4 * i), $urandom());
        end
        drain_replies();
        ready_mode = READY_LOW;
        burst_done = 1'b0;
        stall_seen = 1'b0;
        fork
            begin
                for (int i = 0; i < BURST_LEN; i++) begin
                    send_cmd(OP_MEM_READ, arg_t'(32'h100 + 4 * i));
                end
                burst_done = 1'b1;
            end
            begin
                low_cycles = 0;
                while (low_cycles < 8 && !burst_done) begin
                    @(posedge clk);
                    low_cycles = (cmd_valid && !cmd_ready) ? low_cycles + 1 : 0;
                end
                stall_seen = (low_cycles >= 8);
                ready_mode = READY_RANDOM;  // Let the replies go
            end
        join
        drain_replies();
        assert (stall_seen) else count_failure("cmd_ready never dropped while replies were held");

        repeat (20) wait_cycle();
        assert (reply_idx == exp_q.size())
            else report_mismatch("reply count", reply_idx, exp_q.size());
        assert (pulses_seen == pulses_sent)
            else report_mismatch("write_pulse count", pulses_seen, pulses_sent);
        assert (resets_done == resets_sent)
            else report_mismatch("core_reset sequences", resets_done, resets_sent);
        finish_run();
    end

endmodule

/* verification/tb_mem_model.sv */
module tb_mem_model import debug_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t mem_req,
    output logic     mem_response,
    output word_t    mem_read_data
);

    word_t    store [word_t];
    mem_req_t held;
    int       latency;

    // Locations never written read back as a scramble of their address
    function automatic word_t fill_word(word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_a5a5;
    endfunction

    initial begin
        mem_response  = 1'b0;
        mem_read_data = '0;
        forever begin
            @(posedge clk);
            if (!reset && (mem_req.read || mem_req.write)) begin
                held    = mem_req;
                latency = $urandom_range(1, 4);
                repeat (latency - 1) @(posedge clk);
                #1;
                if (held.write) begin
                    store[held.addr] = held.wdata;
                end else if (store.exists(held.addr)) begin
                    mem_read_data = store[held.addr];
                end else begin
                    mem_read_data = fill_word(held.addr);
                end
                mem_response = 1'b1;  // One cycle only
                @(posedge clk);
                #1;
                mem_response = 1'b0;
            end
        end
    end

endmodule

/* hw/debug_interpreter.sv */
module debug_interpreter import debug_pkg::*; #(
    parameter word_t ID               = 32'h7700006A,
    parameter int    RESET_CLK_CYCLES = 20,
    parameter int    CMD_DEPTH        = 4,
    parameter int    REPLY_DEPTH      = 4,
    parameter int    PULSE_BITS       = 32
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  word_t                 cmd_data,

    output logic                  reply_valid,
    input  logic                  reply_ready,
    output word_t                 reply_data,

    output mem_req_t              mem_req,
    input  logic                  mem_response,
    input  word_t                 mem_read_data,

    output logic                  core_clk_enable,
    output logic                  core_reset,
    output logic                  write_pulse,
    output logic [PULSE_BITS-1:0] cycles_to_pulse
);

    logic                  dec_valid;
    logic                  dec_ready;
    decoded_cmd_t          dec_cmd;
    logic                  exe_valid;
    logic                  exe_ready;
    decoded_cmd_t          exe_cmd;
    logic                  rep_valid;
    logic                  rep_ready;
    word_t                 rep_data;
    logic                  core_valid;
    logic                  core_ready;
    core_op_e              core_op;
    logic [PULSE_BITS-1:0] core_count;

    cmd_decoder u_decoder (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (cmd_valid),
        .in_ready  (cmd_ready),
        .in_data   (cmd_data),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_cmd   (dec_cmd)
    );

    stream_fifo #(
        .payload_t (decoded_cmd_t),
        .DEPTH     (CMD_DEPTH)
    ) u_cmd_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (dec_cmd),
        .out_valid (exe_valid),
        .out_ready (exe_ready),
        .out_data  (exe_cmd)
    );

    cmd_executor #(
        .ID         (ID),
        .PULSE_BITS (PULSE_BITS)
    ) u_executor (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (exe_valid),
        .cmd_ready     (exe_ready),
        .cmd           (exe_cmd),
        .reply_valid   (rep_valid),
        .reply_ready   (rep_ready),
        .reply_data    (rep_data),
        .mem_req       (mem_req),
        .mem_response  (mem_response),
        .mem_read_data (mem_read_data),
        .core_valid    (core_valid),
        .core_ready    (core_ready),
        .core_op       (core_op),
        .core_count    (core_count)
    );

    stream_fifo #(
        .payload_t (word_t),
        .DEPTH     (REPLY_DEPTH)
    ) u_reply_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rep_valid),
        .in_ready  (rep_ready),
        .in_data   (rep_data),
        .out_valid (reply_valid),
        .out_ready (reply_ready),
        .out_data  (reply_data)
    );

    core_control #(
        .RESET_CLK_CYCLES (RESET_CLK_CYCLES),
        .PULSE_BITS       (PULSE_BITS)
    ) u_core_control (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (core_valid),
        .req_ready       (core_ready),
        .op              (core_op),
        .count           (core_count),
        .core_clk_enable (core_clk_enable),
        .core_reset      (core_reset),
        .write_pulse     (write_pulse),
        .cycles_to_pulse (cycles_to_pulse)
    );

endmodule

/* hw/core_control.sv */
module core_control import debug_pkg::*; #(
    parameter int RESET_CLK_CYCLES = 20,
    parameter int PULSE_BITS       = 32
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  req_valid,
    output logic                  req_ready,
    input  core_op_e              op,
    input  logic [PULSE_BITS-1:0] count,

    output logic                  core_clk_enable,
    output logic                  core_reset,
    output logic                  write_pulse,
    output logic [PULSE_BITS-1:0] cycles_to_pulse
);

    localparam int CW = $clog2(RESET_CLK_CYCLES + 1);

    logic [CW-1:0] reset_cnt;
    logic          accept;

    assign req_ready = !core_reset;  // Busy during the reset sequence
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            core_clk_enable <= 1'b0;
            core_reset      <= 1'b0;
            write_pulse     <= 1'b0;
            reset_cnt       <= '0;
        end else begin
            write_pulse <= 1'b0;
            if (core_reset) begin
                reset_cnt <= reset_cnt + 1'b1;
                if (reset_cnt == CW'(RESET_CLK_CYCLES - 1)) begin
                    core_reset      <= 1'b0;
                    core_clk_enable <= 1'b0;  // Core left stopped after reset
                end
            end else if (accept) begin
                case (op)
                    CORE_PULSE: begin
                        core_clk_enable <= 1'b1;
                        write_pulse     <= 1'b1;
                    end
                    CORE_STOP:   core_clk_enable <= 1'b0;
                    CORE_RESUME: core_clk_enable <= 1'b1;
                    CORE_RESET: begin
                        core_reset      <= 1'b1;
                        core_clk_enable <= 1'b1;
                        reset_cnt       <= '0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && op == CORE_PULSE) begin
            cycles_to_pulse <= count;
        end
    end

    assert property (@(posedge clk) disable iff (reset) write_pulse |=> !write_pulse)
        else $error("core_control: write_pulse held longer than one cycle");

endmodule

/* hw/cmd_executor.sv */
module cmd_executor import debug_pkg::*; #(
    parameter word_t ID         = 32'h7700006A,
    parameter int    PULSE_BITS = 32
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  decoded_cmd_t          cmd,

    output logic                  reply_valid,
    input  logic                  reply_ready,
    output word_t                 reply_data,

    output mem_req_t              mem_req,
    input  logic                  mem_response,
    input  word_t                 mem_read_data,

    output logic                  core_valid,
    input  logic                  core_ready,
    output core_op_e              core_op,
    output logic [PULSE_BITS-1:0] core_count
);

    typedef enum logic [2:0] {
        IDLE,
        EXEC,
        MEM_WAIT,
        REPLY,
        CORE_REQ
    } state_e;

    state_e       state;
    decoded_cmd_t cur;
    word_t        acc;
    word_t        arg_word;
    logic         is_read;
    logic         mem_rd;
    logic         mem_wr;
    word_t        mem_addr;
    word_t        mem_wdata;

    assign arg_word    = {8'h00, cur.arg};  // Zero-extended argument
    assign is_read     = (cur.opcode == OP_MEM_READ) || (cur.opcode == OP_READ_ACC);
    assign cmd_ready   = (state == IDLE);
    assign reply_valid = (state == REPLY);
    assign core_valid  = (state == CORE_REQ);
    assign core_count  = PULSE_BITS'(cur.arg);
    assign mem_req     = '{read: mem_rd, write: mem_wr, addr: mem_addr, wdata: mem_wdata};

    always_comb begin
        case (cur.opcode)
            OP_CLK_PULSE:  core_op = CORE_PULSE;
            OP_CLK_STOP:   core_op = CORE_STOP;
            OP_CLK_RESUME: core_op = CORE_RESUME;
            default:       core_op = CORE_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            acc    <= '0;
            mem_rd <= 1'b0;
            mem_wr <= 1'b0;
        end else begin
            mem_rd <= 1'b0;  // Strobes last one cycle
            mem_wr <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    state <= IDLE;
                    case (cur.opcode)
                        OP_ACC_UPPER: acc <= {cur.arg, acc[7:0]};
                        OP_ACC_LOWER: acc <= {acc[31:8], cur.arg[7:0]};
                        OP_ACC_ADD:   acc <= acc + {{8{cur.arg[23]}}, cur.arg};
                        OP_MEM_WRITE, OP_WRITE_ACC, OP_WRITE_N: begin
                            mem_wr <= 1'b1;
                            state  <= MEM_WAIT;
                        end
                        OP_MEM_READ, OP_READ_ACC: begin
                            mem_rd <= 1'b1;
                            state  <= MEM_WAIT;
                        end
                        OP_PING, OP_GET_ACC: state <= REPLY;
                        OP_CLK_PULSE, OP_CLK_STOP, OP_CLK_RESUME, OP_CORE_RESET: begin
                            state <= CORE_REQ;
                        end
                        default: state <= IDLE;
                    endcase
                end
                MEM_WAIT: begin
                    if (mem_response) begin
                        state <= is_read ? REPLY : IDLE;
                    end
                end
                REPLY: begin
                    if (reply_ready) begin
                        state <= IDLE;  // Stalls here while the reply FIFO is full
                    end
                end
                CORE_REQ: begin
                    if (core_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid) begin
            cur <= cmd;
        end
        if (state == EXEC) begin
            case (cur.opcode)
                OP_MEM_WRITE: begin
                    mem_addr  <= arg_word;
                    mem_wdata <= cur.data;
                end
                OP_WRITE_ACC: begin
                    mem_addr  <= arg_word;
                    mem_wdata <= acc;
                end
                OP_WRITE_N: begin
                    mem_addr  <= acc;
                    mem_wdata <= arg_word;
                end
                OP_MEM_READ: mem_addr <= arg_word;
                OP_READ_ACC: mem_addr <= acc;
                OP_PING:     reply_data <= ID;
                OP_GET_ACC:  reply_data <= acc;
                default: ;
            endcase
        end
        if (state == MEM_WAIT && mem_response) begin
            reply_data <= mem_read_data;
        end
    end

    // One strobe at a time, and only for a single cycle
    assert property (@(posedge clk) disable iff (reset)
        (mem_req.read || mem_req.write)
        |-> !(mem_req.read && mem_req.write) ##1 !(mem_req.read || mem_req.write))
        else $error("cmd_executor: bad memory strobe read=%b write=%b",
                    mem_req.read, mem_req.write);

endmodule

/* hw/stream_fifo.sv */
module stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;
    logic          push;
    logic          pop;

    function automatic logic [PW-1:0] wrap_inc(logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push       = in_valid && in_ready;
    assign pop        = out_valid && out_ready;
    assign out_valid  = (count != '0);
    assign out_data   = mem[rd_ptr];
    assign count_next = count + CW'(push) - CW'(pop);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wrap_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= wrap_inc(rd_ptr);
            end
            count    <= count_next;
            in_ready <= (count_next != CW'(DEPTH));  // Registered full flag
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset) (count == CW'(DEPTH)) |-> !push)
        else $error("stream_fifo: push accepted while full");

endmodule

/* hw/cmd_decoder.sv */
module cmd_decoder import debug_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic         in_valid,
    output logic         in_ready,
    input  word_t        in_data,

    output logic         out_valid,
    input  logic         out_ready,
    output decoded_cmd_t out_cmd
);

    logic       w_pending;  // First word of W seen
    arg_t       w_arg;
    logic [7:0] in_code;
    logic       accept;

    assign in_code  = in_data[7:0];
    assign in_ready = out_ready;  // Only take a word when the FIFO has room
    assign accept   = in_valid && in_ready;

    always_comb begin
        if (w_pending) begin
            // Any word completes a pending W regardless of its low byte
            out_valid      = in_valid;
            out_cmd.opcode = OP_MEM_WRITE;
            out_cmd.arg    = w_arg;
            out_cmd.data   = in_data;
        end else begin
            out_valid      = in_valid && is_opcode(in_code) && (in_code != OP_MEM_WRITE);
            out_cmd.opcode = opcode_e'(in_code);
            out_cmd.arg    = in_data[31:8];
            out_cmd.data   = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            w_pending <= 1'b0;
        end else if (accept) begin
            w_pending <= !w_pending && (in_code == OP_MEM_WRITE);
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !w_pending) begin
            w_arg <= in_data[31:8];  // Address of a possible W
        end
    end

    // A W leaves once with its data word, then the next word decodes on its own
    assert property (@(posedge clk) disable iff (reset)
        w_pending && out_valid && out_ready |=> !w_pending)
        else $error("cmd_decoder: W still pending after its data word went out");

endmodule

/* hw/debug_pkg.sv */
package debug_pkg;

    typedef logic [31:0] word_t;
    typedef logic [23:0] arg_t;

    // ASCII opcode characters in the low byte of a host word
    typedef enum logic [7:0] {
        OP_ACC_ADD    = 8'h41,  // A
        OP_CLK_PULSE  = 8'h43,  // C
        OP_READ_ACC   = 8'h47,  // G
        OP_MEM_READ   = 8'h4C,  // L
        OP_CORE_RESET = 8'h52,  // R
        OP_CLK_STOP   = 8'h53,  // S
        OP_ACC_UPPER  = 8'h55,  // U
        OP_MEM_WRITE  = 8'h57,  // W, takes a second word
        OP_GET_ACC    = 8'h61,  // a
        OP_ACC_LOWER  = 8'h6C,  // l
        OP_PING       = 8'h70,  // p
        OP_CLK_RESUME = 8'h72,  // r
        OP_WRITE_N    = 8'h73,  // s
        OP_WRITE_ACC  = 8'h77   // w
    } opcode_e;

    typedef struct packed {
        opcode_e opcode;
        arg_t    arg;
        word_t   data;  // Second word of W, zero otherwise
    } decoded_cmd_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        CORE_PULSE,
        CORE_STOP,
        CORE_RESUME,
        CORE_RESET
    } core_op_e;

    function automatic logic is_opcode(logic [7:0] code);
        case (code)
            OP_ACC_ADD, OP_CLK_PULSE, OP_READ_ACC, OP_MEM_READ, OP_CORE_RESET,
            OP_CLK_STOP, OP_ACC_UPPER, OP_MEM_WRITE, OP_GET_ACC, OP_ACC_LOWER,
            OP_PING, OP_CLK_RESUME, OP_WRITE_N, OP_WRITE_ACC: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage
